// ==== verilog/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Core data width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NREGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// Fetch address on interrupt entry
`define RV_TRAP_VECTOR 32'h0000_0100

`endif

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // Register-register ALU
        OPC_OP_IMM = 7'b0010011, // ADDI
        OPC_LOAD   = 7'b0000011, // LW
        OPC_STORE  = 7'b0100011, // SW
        OPC_BRANCH = 7'b1100011, // BEQ, BNE
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,    // Signed compare
        ALU_PASS_B  // Operand b straight through
    } alu_op_e;

    // Write-back source, load must stay at 1
    typedef enum logic [1:0] {
        RES_ALU  = 2'd0,
        RES_LOAD = 2'd1,
        RES_PC4  = 2'd2
    } result_sel_e;

    // Operand source in EXE
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0, // Register file value from ID
        FWD_WB   = 2'd1,
        FWD_MEM  = 2'd2
    } fwd_sel_e;

endpackage

// ==== verilog/hazard_detection.sv ====
`timescale 1ns/10ps

module hazard_detection
    import rv_pkg::*;
(
    input  logic [4:0]  rs1_id,
    input  logic [4:0]  rs2_id,
    input  logic [4:0]  rs1_exe,
    input  logic [4:0]  rs2_exe,
    input  logic [4:0]  rd_exe,
    input  logic [4:0]  rs2_mem,
    input  logic [4:0]  rd_mem,
    input  logic [4:0]  rd_wb,
    input  result_sel_e result_sel_exe,
    input  logic        pc_next_sel,    // Taken branch or JAL in EXE
    input  logic        interrupt_ctrl, // Pending interrupt request
    output logic        flush_if_id,
    output logic        flush_id_exe,
    output logic        stall_if,
    output logic        stall_if_id,
    output logic        interrupt_en,
    output fwd_sel_e    forwarding_a,
    output fwd_sel_e    forwarding_b,
    output logic        forwarding_mem
);

    logic load_use_hazard;

    // MEM is younger than WB, so it wins when both write the source
    function automatic fwd_sel_e pick_fwd(input logic [4:0] rs);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (rd_mem != 5'd0 && rd_mem == rs) begin
            sel = FWD_MEM;
        end else if (rd_wb != 5'd0 && rd_wb != rd_mem && rd_wb == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb begin
        forwarding_a   = pick_fwd(rs1_exe);
        forwarding_b   = pick_fwd(rs2_exe);
        // Store data still in MEM can lag the value now in WB
        forwarding_mem = (rd_wb != 5'd0) && (rd_wb == rs2_mem);
    end

    // Load result only exists after MEM, so a dependent in ID has to wait
    assign load_use_hazard = (result_sel_exe == RES_LOAD) && (rd_exe != 5'd0) &&
                             ((rs1_id == rd_exe) || (rs2_id == rd_exe));

    // No interrupt while a redirect or a stall is in flight
    assign interrupt_en = interrupt_ctrl && !load_use_hazard && !pc_next_sel;

    always_comb begin
        stall_if     = 1'b0;
        stall_if_id  = 1'b0;
        flush_if_id  = 1'b0;
        flush_id_exe = 1'b0;

        if (load_use_hazard) begin
            stall_if     = 1'b1; // Hold PC
            stall_if_id  = 1'b1; // Hold consumer in ID
            flush_id_exe = 1'b1; // Bubble into EXE
        end

        // Redirect kills the IF and ID instructions
        if (pc_next_sel) begin
            flush_if_id = 1'b1;
        end

        if (interrupt_en) begin
            flush_if_id  = 1'b1;
            flush_id_exe = 1'b1;
        end
    end

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module decoder
    import rv_pkg::*;
(
    input  logic [31:0]         instr,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output logic [`RV_XLEN-1:0] imm,
    output alu_op_e             alu_op,
    output logic                alu_src_imm, // Operand b from imm
    output logic                mem_write,
    output logic                is_branch,
    output logic                branch_ne,   // BNE when set, BEQ otherwise
    output logic                is_jal,
    output logic                valid_op,
    output result_sel_e         result_sel
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        rs1         = instr[19:15];
        rs2         = instr[24:20];
        rd          = instr[11:7];
        imm         = imm_i;
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        mem_write   = 1'b0;
        is_branch   = 1'b0;
        branch_ne   = 1'b0;
        is_jal      = 1'b0;
        result_sel  = RES_ALU;
        valid_op    = 1'b1;

        case (opcode)
            OPC_OP: begin
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: valid_op = 1'b0;
                endcase
                // Only SUB may carry funct7 bit 5
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    valid_op = 1'b0;
                end
            end
            OPC_OP_IMM: begin // ADDI only
                rs2         = 5'd0;
                alu_src_imm = 1'b1;
                valid_op    = (funct3 == 3'b000);
            end
            OPC_LOAD: begin
                rs2         = 5'd0;
                alu_src_imm = 1'b1;
                result_sel  = RES_LOAD;
                valid_op    = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                rd          = 5'd0;
                imm         = imm_s;
                alu_src_imm = 1'b1; // Address is rs1 + imm
                mem_write   = 1'b1;
                valid_op    = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                rd        = 5'd0;
                imm       = imm_b;
                alu_op    = ALU_SUB;
                is_branch = 1'b1;
                branch_ne = funct3[0];
                valid_op  = (funct3[2:1] == 2'b00);
            end
            OPC_JAL: begin
                rs1        = 5'd0;
                rs2        = 5'd0;
                imm        = imm_j;
                alu_op     = ALU_PASS_B;
                is_jal     = 1'b1;
                result_sel = RES_PC4; // Link value
            end
            default: valid_op = 1'b0;
        endcase

        // Anything unknown behaves as a bubble
        if (!valid_op) begin
            rs1        = 5'd0;
            rs2        = 5'd0;
            rd         = 5'd0;
            mem_write  = 1'b0;
            is_branch  = 1'b0;
            is_jal     = 1'b0;
            result_sel = RES_ALU;
        end
    end

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module execute_stage
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] alu_result_mem, // Result of the MEM instruction
    input  logic [`RV_XLEN-1:0] wb_data,
    input  fwd_sel_e            forwarding_a,
    input  fwd_sel_e            forwarding_b,
    input  alu_op_e             alu_op,
    input  logic                alu_src_imm,
    input  logic                is_branch,
    input  logic                branch_ne,
    input  logic                is_jal,
    input  logic                valid,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] store_data,
    output logic [`RV_XLEN-1:0] branch_target,
    output logic                pc_next_sel
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b_reg; // Forwarded rs2 before the imm mux
    logic [`RV_XLEN-1:0] op_b;
    logic                equal;

    always_comb begin
        case (forwarding_a)
            FWD_MEM: op_a = alu_result_mem;
            FWD_WB:  op_a = wb_data;
            default: op_a = rs1_data;
        endcase
        case (forwarding_b)
            FWD_MEM: op_b_reg = alu_result_mem;
            FWD_WB:  op_b_reg = wb_data;
            default: op_b_reg = rs2_data;
        endcase
    end

    assign op_b       = alu_src_imm ? imm : op_b_reg;
    assign store_data = op_b_reg;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_b; // PASS_B
        endcase
    end

    // Branch compare on the register operands
    assign equal         = (op_a == op_b_reg);
    assign branch_target = pc + imm; // Same adder for B and J offsets
    assign pc_next_sel   = valid && (is_jal || (is_branch && (branch_ne ? !equal : equal)));

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module reg_file (
    input  logic                clk,
    input  logic                we,
    input  logic [4:0]          ra1,
    input  logic [4:0]          ra2,
    input  logic [4:0]          wa,
    input  logic [`RV_XLEN-1:0] wd,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd; // x0 never written
        end
    end

    // Write in the same cycle shows up on the read ports
    assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module data_mem (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] addr,  // Byte address, low bits ignored
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata
);

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
    logic [AW-1:0]       idx;

    assign idx = addr[AW+1:2]; // Wraps modulo depth

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                mem[i] <= '0; // Known-zero start
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                irq,          // Level, held until irq_ack
    input  logic [31:0]         imem_rdata,
    output logic [31:0]         imem_addr,
    output logic                retire_valid,
    output logic [31:0]         retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_wdata,
    output logic                irq_ack,
    output logic [31:0]         irq_epc
);

    logic [31:0]         pc;
    logic                if_id_valid;
    logic [31:0]         if_id_pc;
    logic [31:0]         if_id_instr;
    logic [31:0]         instr_id;
    logic [4:0]          rs1_id, rs2_id, rd_id;
    logic [`RV_XLEN-1:0] imm_id, rs1_data_id, rs2_data_id;
    alu_op_e             alu_op_id;
    logic                alu_src_imm_id, mem_write_id, is_branch_id;
    logic                branch_ne_id, is_jal_id, valid_op_id;
    result_sel_e         result_sel_id;
    logic                valid_exe;
    logic [31:0]         pc_exe;
    logic [4:0]          rs1_exe, rs2_exe, rd_exe;
    logic [`RV_XLEN-1:0] imm_exe, rs1_data_exe, rs2_data_exe;
    alu_op_e             alu_op_exe;
    logic                alu_src_imm_exe, mem_write_exe, is_branch_exe;
    logic                branch_ne_exe, is_jal_exe;
    result_sel_e         result_sel_exe;
    logic [`RV_XLEN-1:0] alu_result_exe, store_data_exe, branch_target_exe;
    logic                pc_next_sel;
    logic                valid_mem;
    logic [31:0]         pc_mem;
    logic [4:0]          rs2_mem, rd_mem;
    logic [`RV_XLEN-1:0] alu_result_mem, store_data_mem;
    logic                mem_write_mem;
    result_sel_e         result_sel_mem;
    logic [`RV_XLEN-1:0] fwd_mem_data, mem_wdata, load_data;
    logic                valid_wb;
    logic [31:0]         pc_wb;
    logic [4:0]          rd_wb;
    logic [`RV_XLEN-1:0] alu_result_wb, load_data_wb, wb_data;
    result_sel_e         result_sel_wb;
    logic                flush_if_id, flush_id_exe, stall_if, stall_if_id, interrupt_en;
    fwd_sel_e            forwarding_a, forwarding_b;
    logic                forwarding_mem;

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (interrupt_en) begin
            pc <= `RV_TRAP_VECTOR;
        end else if (pc_next_sel) begin
            pc <= branch_target_exe; // Resolved in EXE
        end else if (!stall_if) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_if_id) begin
            if_id_valid <= 1'b0;
        end else if (!stall_if_id) begin
            if_id_valid <= 1'b1;
            if_id_pc    <= pc;
            if_id_instr <= imem_rdata;
        end
    end

    // A bubble decodes as an unknown opcode
    assign instr_id = if_id_valid ? if_id_instr : '0;

    decoder i_decoder (
        .instr       (instr_id),
        .rs1         (rs1_id),
        .rs2         (rs2_id),
        .rd          (rd_id),
        .imm         (imm_id),
        .alu_op      (alu_op_id),
        .alu_src_imm (alu_src_imm_id),
        .mem_write   (mem_write_id),
        .is_branch   (is_branch_id),
        .branch_ne   (branch_ne_id),
        .is_jal      (is_jal_id),
        .valid_op    (valid_op_id),
        .result_sel  (result_sel_id)
    );

    reg_file i_reg_file (
        .clk (clk),
        .we  (valid_wb),
        .ra1 (rs1_id),
        .ra2 (rs2_id),
        .wa  (rd_wb),
        .wd  (wb_data),
        .rd1 (rs1_data_id),
        .rd2 (rs2_data_id)
    );

    always_ff @(posedge clk) begin
        if (rst || flush_id_exe || flush_if_id) begin
            valid_exe      <= 1'b0; // Bubble
            rs1_exe        <= 5'd0;
            rs2_exe        <= 5'd0;
            rd_exe         <= 5'd0;
            mem_write_exe  <= 1'b0;
            is_branch_exe  <= 1'b0;
            is_jal_exe     <= 1'b0;
            result_sel_exe <= RES_ALU;
        end else begin
            valid_exe       <= valid_op_id;
            pc_exe          <= if_id_pc;
            rs1_exe         <= rs1_id;
            rs2_exe         <= rs2_id;
            rd_exe          <= rd_id;
            imm_exe         <= imm_id;
            rs1_data_exe    <= rs1_data_id;
            rs2_data_exe    <= rs2_data_id;
            alu_op_exe      <= alu_op_id;
            alu_src_imm_exe <= alu_src_imm_id;
            mem_write_exe   <= mem_write_id;
            is_branch_exe   <= is_branch_id;
            branch_ne_exe   <= branch_ne_id;
            is_jal_exe      <= is_jal_id;
            result_sel_exe  <= result_sel_id;
        end
    end

    execute_stage i_execute_stage (
        .pc             (pc_exe),
        .imm            (imm_exe),
        .rs1_data       (rs1_data_exe),
        .rs2_data       (rs2_data_exe),
        .alu_result_mem (fwd_mem_data),
        .wb_data        (wb_data),
        .forwarding_a   (forwarding_a),
        .forwarding_b   (forwarding_b),
        .alu_op         (alu_op_exe),
        .alu_src_imm    (alu_src_imm_exe),
        .is_branch      (is_branch_exe),
        .branch_ne      (branch_ne_exe),
        .is_jal         (is_jal_exe),
        .valid          (valid_exe),
        .alu_result     (alu_result_exe),
        .store_data     (store_data_exe),
        .branch_target  (branch_target_exe),
        .pc_next_sel    (pc_next_sel)
    );

    // EXE always moves on, the interrupt lets it finish
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem      <= 1'b0;
            rs2_mem        <= 5'd0;
            rd_mem         <= 5'd0;
            mem_write_mem  <= 1'b0;
            result_sel_mem <= RES_ALU;
        end else begin
            valid_mem      <= valid_exe;
            pc_mem         <= pc_exe;
            rs2_mem        <= rs2_exe;
            rd_mem         <= rd_exe;
            alu_result_mem <= alu_result_exe;
            store_data_mem <= store_data_exe;
            mem_write_mem  <= mem_write_exe && valid_exe;
            result_sel_mem <= result_sel_exe;
        end
    end

    // JAL in MEM forwards its link value, not the ALU output
    assign fwd_mem_data = (result_sel_mem == RES_PC4) ? pc_mem + 32'd4 : alu_result_mem;
    assign mem_wdata    = forwarding_mem ? wb_data : store_data_mem;

    data_mem i_data_mem (
        .clk   (clk),
        .rst   (rst),
        .we    (mem_write_mem),
        .addr  (alu_result_mem),
        .wdata (mem_wdata),
        .rdata (load_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_wb      <= 1'b0;
            rd_wb         <= 5'd0;
            result_sel_wb <= RES_ALU;
        end else begin
            valid_wb      <= valid_mem;
            pc_wb         <= pc_mem;
            rd_wb         <= rd_mem;
            alu_result_wb <= alu_result_mem;
            load_data_wb  <= load_data;
            result_sel_wb <= result_sel_mem;
        end
    end

    always_comb begin
        case (result_sel_wb)
            RES_LOAD: wb_data = load_data_wb;
            RES_PC4:  wb_data = pc_wb + 32'd4;
            default:  wb_data = alu_result_wb;
        endcase
    end

    assign retire_valid = valid_wb;
    assign retire_pc    = pc_wb;
    assign retire_rd    = rd_wb;
    assign retire_wdata = (rd_wb == 5'd0) ? '0 : wb_data; // x0 reads as zero

    hazard_detection i_hazard_detection (
        .rs1_id         (rs1_id),
        .rs2_id         (rs2_id),
        .rs1_exe        (rs1_exe),
        .rs2_exe        (rs2_exe),
        .rd_exe         (rd_exe),
        .rs2_mem        (rs2_mem),
        .rd_mem         (rd_mem),
        .rd_wb          (rd_wb),
        .result_sel_exe (result_sel_exe),
        .pc_next_sel    (pc_next_sel),
        .interrupt_ctrl (irq && !irq_ack), // Request still high during the ack cycle
        .flush_if_id    (flush_if_id),
        .flush_id_exe   (flush_id_exe),
        .stall_if       (stall_if),
        .stall_if_id    (stall_if_id),
        .interrupt_en   (interrupt_en),
        .forwarding_a   (forwarding_a),
        .forwarding_b   (forwarding_b),
        .forwarding_mem (forwarding_mem)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_ack <= 1'b0;
        end else begin
            irq_ack <= interrupt_en;
        end
    end

    // Oldest killed instruction resumes after the handler
    always_ff @(posedge clk) begin
        if (interrupt_en) begin
            irq_epc <= if_id_valid ? if_id_pc : pc;
        end
    end

endmodule

// ==== sim/tb_iss.svh ====
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// Architectural state of the reference model
logic [31:0] model_regs [32];
logic [31:0] model_mem  [`RV_DMEM_WORDS];

// Data memory starts at zero after reset, registers get set by the program preamble
task automatic reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
        model_mem[i] = '0;
    end
endtask

// Executes one instruction, returns its write-back and the PC that follows it
task automatic step_instr(
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [4:0]  rd,
    output logic [31:0] wdata,
    output logic [31:0] next_pc,
    output logic        legal
);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    int unsigned word;

    a       = model_regs[instr[19:15]];
    b       = model_regs[instr[24:20]];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    rd      = instr[11:7];
    wdata   = '0;
    next_pc = pc + 32'd4;
    legal   = 1'b1;

    case (instr[6:0])
        7'h33: begin
            case ({instr[31:25], instr[14:12]}) // funct7 and funct3
                10'b0000000_000: wdata = a + b;
                10'b0100000_000: wdata = a - b;
                10'b0000000_010: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                10'b0000000_100: wdata = a ^ b;
                10'b0000000_110: wdata = a | b;
                10'b0000000_111: wdata = a & b;
                default:         legal = 1'b0;
            endcase
        end
        7'h13: wdata = a + imm_i; // ADDI
        7'h03: begin
            word  = ((a + imm_i) >> 2) % `RV_DMEM_WORDS; // Wraps with the memory depth
            wdata = model_mem[word];
        end
        7'h23: begin
            word            = ((a + imm_s) >> 2) % `RV_DMEM_WORDS;
            model_mem[word] = b;
            rd              = 5'd0;
        end
        7'h63: begin
            rd = 5'd0;
            if (instr[12] ? (a != b) : (a == b)) begin // BNE or BEQ
                next_pc = pc + imm_b;
            end
        end
        7'h6f: begin
            wdata   = pc + 32'd4; // Link
            next_pc = pc + imm_j;
        end
        default: legal = 1'b0;
    endcase

    if (!legal) begin
        rd = 5'd0;
    end
    if (rd == 5'd0) begin
        wdata = '0; // x0 stays zero
    end else begin
        model_regs[rd] = wdata;
    end
endtask

`endif

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/10ps
`include "rv_defines.svh"

module tb_rv_core;

    localparam int          NUM_RUNS     = 20;
    localparam int          PROG_LEN     = 40;
    localparam int          IMEM_WORDS   = 128;
    localparam logic [31:0] HALT_INSTR   = 32'h0000_006f; // JAL x0,0
    localparam int          RETIRE_LIMIT = 16;  // Longest gap between two retirements
    localparam int          ACK_LIMIT    = 32;
    localparam int          RUN_LIMIT    = 400;

    logic        clk;
    logic        rst;
    logic        irq;
    logic [31:0] imem_rdata;
    logic [31:0] imem_addr;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic        irq_ack;
    logic [31:0] irq_epc;

    logic [31:0] imem [IMEM_WORDS]; // Program, wrong-path filler and trap word

    `include "tb_iss.svh"

    rv_core i_dut (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .imem_rdata   (imem_rdata),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_wdata (retire_wdata),
        .irq_ack      (irq_ack),
        .irq_epc      (irq_epc)
    );

    assign imem_rdata = imem[imem_addr[8:2]]; // Same-cycle fetch

    always #4 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic build_program();
        int         span;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = enc_i(7'h13, 3'b000, 5'd0, 5'd0, 12'(i)); // NOP tagged with its index
        end
        for (int i = 1; i < 8; i++) begin
            imem[i - 1] = enc_i(7'h13, 3'b000, 5'(i), 5'd0, 12'($urandom)); // Seed x1..x7
        end
        for (int i = 7; i < PROG_LEN - 1; i++) begin
            rd   = 5'($urandom % 8); // Few registers, dense hazards
            rs1  = 5'($urandom % 8);
            rs2  = 5'($urandom % 8);
            span = 1 + $urandom % 4;
            if (i + span > PROG_LEN - 1) begin
                span = PROG_LEN - 1 - i; // Never past the halt loop
            end
            f7 = 7'h00;
            case ($urandom % 6)
                0:       f3 = 3'b000;
                1: begin
                    f3 = 3'b000;
                    f7 = 7'h20; // SUB
                end
                2:       f3 = 3'b111;
                3:       f3 = 3'b110;
                4:       f3 = 3'b100;
                default: f3 = 3'b010;
            endcase
            case ($urandom % 10)
                0, 1, 2, 3: imem[i] = enc_r(f7, f3, rd, rs1, rs2);
                4:          imem[i] = enc_i(7'h13, 3'b000, rd, rs1, 12'($urandom));
                5:          imem[i] = enc_i(7'h03, 3'b010, rd, 5'd0, 12'(($urandom % 16) * 4));
                6:          imem[i] = enc_s(5'd0, rs2, 12'(($urandom % 16) * 4));
                7, 8:       imem[i] = enc_b({2'b00, 1'($urandom)}, rs1, rs2, 13'(span * 4));
                default:    imem[i] = enc_j(rd, 21'(span * 4));
            endcase
        end
        imem[PROG_LEN - 1]         = HALT_INSTR;
        imem[`RV_TRAP_VECTOR >> 2] = HALT_INSTR; // Handler spins too
    endtask

    task automatic run_program(input int run, input logic with_irq);
        logic [31:0] exp_pc;
        logic [31:0] epc;
        logic [31:0] instr;
        logic [31:0] next_pc;
        logic [31:0] wdata;
        logic [4:0]  rd;
        logic        legal;
        logic        acked;
        logic        redirected;
        logic        done;
        int          irq_cycle;
        int          cycle;
        int          idle;
        int          retired;

        build_program();
        reset_model();
        irq_cycle = 4 + $urandom % 100;
        @(posedge clk);
        rst <= 1'b1;
        irq <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_value("retire_valid", 32'd0, 32'(retire_valid));
        check_value("irq_ack", 32'd0, 32'(irq_ack));
        check_value("imem_addr", 32'd0, imem_addr);

        exp_pc     = '0;
        epc        = '0;
        acked      = 1'b0;
        redirected = 1'b0;
        done       = 1'b0;
        cycle      = 0;
        idle       = 0;
        retired    = 0;
        while (!done) begin
            @(posedge clk);
            cycle++;
            if (retire_valid) begin
                idle = 0;
                retired++;
                check_value("retire_pc", exp_pc, retire_pc);
                instr = imem[exp_pc[8:2]];
                step_instr(exp_pc, instr, rd, wdata, next_pc, legal);
                if (!legal) begin
                    $display("Model met an unknown instruction 0x%08h in run %0d", instr, run);
                    abort_run();
                end
                check_value("retire_rd", 32'(rd), 32'(retire_rd));
                check_value("retire_wdata", wdata, retire_wdata);
                if (instr == HALT_INSTR) begin
                    done = with_irq ? (exp_pc == `RV_TRAP_VECTOR) : 1'b1;
                end
                exp_pc = next_pc;
            end else begin
                idle++;
            end
            if (irq_ack) begin
                if (acked || !with_irq) begin
                    $display("Interrupt was acknowledged with no request pending in run %0d", run);
                    abort_run();
                end
                acked = 1'b1;
                epc   = irq_epc;
                irq  <= 1'b0;
                if (epc < exp_pc) begin
                    $display("Interrupt return PC 0x%08h was already retired in run %0d",
                             epc, run);
                    abort_run();
                end
            end
            // Older instructions drain, then the handler takes the killed PC's place
            if (acked && !redirected && exp_pc == epc) begin
                exp_pc     = `RV_TRAP_VECTOR;
                redirected = 1'b1;
            end
            if (with_irq && cycle == irq_cycle) begin
                irq <= 1'b1; // Level request
            end
            if (idle > RETIRE_LIMIT) begin
                $display("No instruction retired for %0d cycles in run %0d", idle, run);
                abort_run();
            end
            if (with_irq && !acked && cycle > irq_cycle + ACK_LIMIT) begin
                $display("Interrupt was never acknowledged in run %0d", run);
                abort_run();
            end
            if (cycle > RUN_LIMIT) begin
                $display("Program did not reach its halt loop in run %0d", run);
                abort_run();
            end
        end
        $display("Run %0d done, %0d retirements, irq %0d", run, retired, with_irq);
    endtask

    initial begin
        int unsigned seed;
        clk    = 1'b0;
        rst    = 1'b1;
        irq    = 1'b0;
        seed   = 32'h930a_d36b;
        void'($urandom(seed));
        for (int run = 0; run < NUM_RUNS; run++) begin
            run_program(run, 1'(run % 2)); // Odd runs take an interrupt
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verilog
+incdir+sim
verilog/rv_pkg.sv
verilog/hazard_detection.sv
verilog/decoder.sv
verilog/execute_stage.sv
verilog/reg_file.sv
verilog/data_mem.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/hazard_detection.sv
      - verilog/decoder.sv
      - verilog/execute_stage.sv
      - verilog/reg_file.sv
      - verilog/data_mem.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - verilog
      - sim
    files:
      - sim/tb_rv_core.sv
